// ==== logic/gem_cfg.svh ====
`ifndef GEM_CFG_SVH
`define GEM_CFG_SVH

// ------------------------------
// cluster format
// ------------------------------
`define GEM_MXCLST      4     // clusters per bunch crossing
`define GEM_CLST_BITS   14    // one packed cluster
`define GEM_ADR_BITS    11    // pad address
`define GEM_CNT_BITS    3     // cluster size
`define GEM_LINK_BITS   56    // decoded link word, four clusters
`define GEM_SEL_BITS    2     // cluster select on readout

// ------------------------------
// memories
// ------------------------------
`define GEM_INJ_DEPTH   1024  // injector time bins per cluster
`define GEM_INJ_ADRB    10
`define GEM_RAW_DEPTH   2048  // raw-hits storage depth
`define GEM_RAW_ADRB    11
`define GEM_TBIN_BITS   12    // last tbin and tbin counter, may wrap the ram

// ------------------------------
// wishbone map
// ------------------------------
`define GEM_WB_ADRB           13       // word address
`define GEM_WB_DATB           16
`define GEM_WB_LAST_TBIN_ADR  13'h1000 // last time bin register

`endif

// ==== logic/gem_pkg.sv ====
`include "gem_cfg.svh"

package gem_pkg;

  // one cluster, size on top of pad address
  typedef struct packed {
    logic [`GEM_CNT_BITS-1:0] cnt; // cluster size
    logic [`GEM_ADR_BITS-1:0] adr; // pad address, 10:9 both set means empty
  } cluster_t;

  // all clusters of one bx, element 0 in the low bits
  typedef cluster_t [`GEM_MXCLST-1:0] cluster_vec_t;

  // raw-hits ram word, odd parity per 7 bit half
  typedef struct packed {
    logic                         par_hi; // odd parity of hi
    logic [`GEM_CLST_BITS/2-1:0]  hi;     // cluster bits 13:7
    logic                         par_lo; // odd parity of lo
    logic [`GEM_CLST_BITS/2-1:0]  lo;     // cluster bits 6:0
  } raw_word_t;

  // injector ram word as written by the host
  typedef struct packed {
    logic [`GEM_WB_DATB-`GEM_CLST_BITS-1:0] spare; // stored and read back only
    cluster_t                               clst;  // injected cluster
  } inj_word_t;

  // wishbone classic master request, held until ack
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`GEM_WB_ADRB-1:0] adr; // word address
    logic [`GEM_WB_DATB-1:0] dat; // write data
  } wb_req_t;

endpackage

// ==== logic/gem_dpram.sv ====
module gem_dpram #(
  parameter type payload_t = logic [15:0], // stored word
  parameter int  depth     = 1024,
  parameter int  adr_bits  = 10,           // log2 of depth
  parameter bit  init_ones = 1'b0          // power up with every bit set
) (
  input  logic                clock,
  input  logic                wen,   // write strobe
  input  logic [adr_bits-1:0] wadr,
  input  payload_t            wdata,
  input  logic [adr_bits-1:0] radr,
  output payload_t            rdata  // one clock after radr
);

  payload_t mem [depth]; // block ram array

  // fpga block ram init, injector rams start out as empty clusters
  initial begin
    if (init_ones) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] = '1;
      end
    end
  end

  always @(posedge clock) begin
    if (wen) begin
      mem[wadr] <= wdata; // write port
    end
  end

  always_ff @(posedge clock) begin
    rdata <= mem[radr]; // read first, same address collision returns old word
  end

endmodule

// ==== logic/gem_inj_sequencer.sv ====
`include "gem_cfg.svh"

module gem_inj_sequencer (
  input  logic                      clock,
  input  logic                      sm_reset,
  input  logic                      inj_go,    // one clock start pulse
  input  logic [`GEM_TBIN_BITS-1:0] last_tbin, // final tbin of the injection
  output logic [`GEM_INJ_ADRB-1:0]  inj_tbin,  // injector ram read address
  output logic                      inj_pass   // 1 = pass link data
);

  typedef enum logic {
    PASS,      // link data to the front end
    INJECTING  // stepping through the injector rams
  } inj_state_t;

  inj_state_t                inj_sm;
  logic [`GEM_TBIN_BITS-1:0] inj_tbin_cnt; // 0-4095
  logic                      inj_tbin_done;

  // ------------------------------
  // pass / injecting fsm
  // ------------------------------
  assign inj_tbin_done = (inj_tbin_cnt == last_tbin); // last_tbin+1 bins read

  always_ff @(posedge clock) begin
    if (sm_reset) begin
      inj_sm <= PASS;
    end else begin
      case (inj_sm)
        PASS:      if (inj_go)        inj_sm <= INJECTING;
        INJECTING: if (inj_tbin_done) inj_sm <= PASS;
        default:                      inj_sm <= PASS;
      endcase
    end
  end

  // ------------------------------
  // tbin counter
  // ------------------------------
  always_ff @(posedge clock) begin
    if (sm_reset || inj_sm == PASS) begin
      inj_tbin_cnt <= '0;                 // held at 0 while passing
    end else begin
      inj_tbin_cnt <= inj_tbin_cnt + 1'b1; // one tbin per bx
    end
  end

  // low bits address the ram, counter can wrap past the depth
  assign inj_tbin = inj_tbin_cnt[`GEM_INJ_ADRB-1:0];

  // select flag lags the state by one clock, matching the ram read
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      inj_pass <= 1'b1;
    end else begin
      inj_pass <= (inj_sm == PASS);
    end
  end

endmodule

// ==== logic/gem_cluster_front.sv ====
`include "gem_cfg.svh"

module gem_cluster_front (
  input  logic                      clock,
  input  logic                      sm_reset,
  input  logic [`GEM_LINK_BITS-1:0] link_data,    // decoded link word
  input  gem_pkg::cluster_vec_t     inj_clusters, // injector ram outputs
  input  logic                      inj_pass,     // 1 = link, 0 = injector
  output gem_pkg::cluster_vec_t     clusters,     // registered clusters
  output logic [`GEM_MXCLST-1:0]    vpf           // cluster valid flags
);

  gem_pkg::cluster_vec_t link_clst; // link word split into clusters
  gem_pkg::cluster_vec_t sel_clst;  // after the source select

  // ------------------------------
  // unpack and select
  // ------------------------------
  genvar iclst;
  generate
    for (iclst = 0; iclst < `GEM_MXCLST; iclst++) begin : g_unpack
      // cluster i sits at bits 14i+13 to 14i
      assign link_clst[iclst] = link_data[iclst*`GEM_CLST_BITS +: `GEM_CLST_BITS];
    end
  endgenerate

  assign sel_clst = inj_pass ? link_clst : inj_clusters; // whole bx switches at once

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      clusters <= '1;       // all ones is an empty bx
    end else begin
      clusters <= sel_clst;
    end
  end

  // valid unless address 10:9 both set, taken after the register
  generate
    for (iclst = 0; iclst < `GEM_MXCLST; iclst++) begin : g_vpf
      assign vpf[iclst] = ~(&clusters[iclst].adr[`GEM_ADR_BITS-1:`GEM_ADR_BITS-2]);
    end
  endgenerate

endmodule

// ==== logic/gem_rawhits_store.sv ====
`include "gem_cfg.svh"

module gem_rawhits_store (
  input  logic                     clock,
  input  gem_pkg::cluster_vec_t    clusters,   // front end clusters
  input  logic                     fifo_wen,   // store this bx
  input  logic [`GEM_RAW_ADRB-1:0] fifo_wadr,
  input  logic [`GEM_RAW_ADRB-1:0] fifo_radr,
  input  logic [`GEM_SEL_BITS-1:0] fifo_sel,   // cluster 0-3 on readout
  output gem_pkg::cluster_t        fifo_rdata, // selected stored cluster
  output logic [`GEM_MXCLST-1:0]   parity_err  // per cluster, either half bad
);

  localparam int HALF = `GEM_CLST_BITS / 2; // 7 bit halves

  gem_pkg::raw_word_t            wr_word [`GEM_MXCLST]; // data plus parity to ram
  gem_pkg::raw_word_t            rd_word [`GEM_MXCLST]; // readback from ram
  logic [`GEM_SEL_BITS-1:0]      sel_q;                 // select lined up with rdata
  logic [`GEM_CLST_BITS-1:0]     rd_flat;

  genvar iclst;
  generate
    for (iclst = 0; iclst < `GEM_MXCLST; iclst++) begin : g_raw
      // ------------------------------
      // write side parity
      // ------------------------------
      assign wr_word[iclst].lo     = clusters[iclst][HALF-1:0];
      assign wr_word[iclst].hi     = clusters[iclst][`GEM_CLST_BITS-1:HALF];
      assign wr_word[iclst].par_lo = ~(^clusters[iclst][HALF-1:0]);              // odd
      assign wr_word[iclst].par_hi = ~(^clusters[iclst][`GEM_CLST_BITS-1:HALF]); // odd

      gem_dpram #(
        .payload_t (gem_pkg::raw_word_t),
        .depth     (`GEM_RAW_DEPTH),
        .adr_bits  (`GEM_RAW_ADRB),
        .init_ones (1'b0)
      ) u_raw_ram (
        .clock (clock),
        .wen   (fifo_wen),
        .wadr  (fifo_wadr),
        .wdata (wr_word[iclst]),
        .radr  (fifo_radr),
        .rdata (rd_word[iclst])
      );

      // ------------------------------
      // read side check
      // ------------------------------
      assign parity_err[iclst] = (rd_word[iclst].par_lo != ~(^rd_word[iclst].lo)) |
                                 (rd_word[iclst].par_hi != ~(^rd_word[iclst].hi));
    end
  endgenerate

  always_ff @(posedge clock) begin
    sel_q <= fifo_sel; // same clock as the ram read
  end

  // readout mux, halves rejoined into a cluster
  assign rd_flat    = {rd_word[sel_q].hi, rd_word[sel_q].lo};
  assign fifo_rdata = gem_pkg::cluster_t'(rd_flat);

endmodule

// ==== logic/gem_wb_slave.sv ====
`include "gem_cfg.svh"

module gem_wb_slave (
  input  logic                      clock,
  input  logic                      sm_reset,
  input  gem_pkg::wb_req_t          wb_req,       // held by the master until ack
  output logic [`GEM_WB_DATB-1:0]   wb_dat_o,     // valid while ack
  output logic                      wb_ack,
  input  logic [`GEM_INJ_ADRB-1:0]  inj_tbin,     // sequencer read address
  output gem_pkg::cluster_vec_t     inj_clusters, // injector data to the front end
  output logic [`GEM_TBIN_BITS-1:0] last_tbin     // final injection tbin
);

  logic [1:0]               wb_cnt;     // 0 idle, 1 wait state, 2 ack
  logic                     wb_wr;      // write strobe, edge where ack rises
  logic                     wb_inj;     // adr bit 12 low, injector space
  logic                     wb_last;    // last tbin register hit
  logic [`GEM_WB_DATB-1:0]  rd_mux;     // readback before the ack gate
  logic [`GEM_MXCLST-1:0]   inj_wen;
  logic [`GEM_MXCLST-1:0]   host_rd;    // host owns the read port this clock
  logic [`GEM_INJ_ADRB-1:0] inj_radr [`GEM_MXCLST];
  gem_pkg::inj_word_t       inj_rdata [`GEM_MXCLST];

  // ------------------------------
  // wait-state counter
  // ------------------------------
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      wb_cnt <= 2'd0;
    end else begin
      case (wb_cnt)
        2'd0:    if (wb_req.cyc && wb_req.stb) wb_cnt <= 2'd1; // request seen
        2'd1:    wb_cnt <= 2'd2;                             // ram read done
        default: wb_cnt <= 2'd0;                             // skip the held stb
      endcase
    end
  end

  assign wb_ack  = (wb_cnt == 2'd2); // single clock
  assign wb_wr   = (wb_cnt == 2'd1) && wb_req.we;
  assign wb_inj  = ~wb_req.adr[12];
  assign wb_last = (wb_req.adr == `GEM_WB_LAST_TBIN_ADR);

  // last tbin register
  always_ff @(posedge clock) begin
    if (sm_reset) begin
      last_tbin <= '0;
    end else if (wb_wr && wb_last) begin
      last_tbin <= wb_req.dat[`GEM_TBIN_BITS-1:0];
    end
  end

  // ------------------------------
  // injector rams
  // ------------------------------
  genvar iclst;
  generate
    for (iclst = 0; iclst < `GEM_MXCLST; iclst++) begin : g_inj
      // adr 11:10 picks the cluster, 9:0 the tbin
      assign inj_wen[iclst] = wb_wr && wb_inj && (wb_req.adr[11:10] == iclst);
      assign host_rd[iclst] = (wb_cnt == 2'd1) && !wb_req.we && wb_inj &&
                              (wb_req.adr[11:10] == iclst);
      // host readback steals one read from the sequencer
      assign inj_radr[iclst] = host_rd[iclst] ? wb_req.adr[`GEM_INJ_ADRB-1:0] : inj_tbin;

      gem_dpram #(
        .payload_t (gem_pkg::inj_word_t),
        .depth     (`GEM_INJ_DEPTH),
        .adr_bits  (`GEM_INJ_ADRB),
        .init_ones (1'b1)                 // unwritten tbins read as empty
      ) u_inj_ram (
        .clock (clock),
        .wen   (inj_wen[iclst]),
        .wadr  (wb_req.adr[`GEM_INJ_ADRB-1:0]),
        .wdata (gem_pkg::inj_word_t'(wb_req.dat)),
        .radr  (inj_radr[iclst]),
        .rdata (inj_rdata[iclst])
      );

      assign inj_clusters[iclst] = inj_rdata[iclst].clst; // spare bits dropped
    end
  endgenerate

  // ------------------------------
  // readback
  // ------------------------------
  always_comb begin
    rd_mux = '0; // unmapped addresses read zero
    if (wb_inj) begin
      rd_mux = inj_rdata[wb_req.adr[11:10]];
    end else if (wb_last) begin
      rd_mux = {{(`GEM_WB_DATB-`GEM_TBIN_BITS){1'b0}}, last_tbin};
    end
  end

  assign wb_dat_o = wb_ack ? rd_mux : '0;

endmodule

// ==== logic/gem_top.sv ====
`include "gem_cfg.svh"

module gem_top (
  input  logic                      clock,
  input  logic                      sm_reset,
  // link
  input  logic [`GEM_LINK_BITS-1:0] link_data,  // four clusters per bx
  input  logic                      inj_go,     // start injection
  // raw-hits ram
  input  logic                      fifo_wen,
  input  logic [`GEM_RAW_ADRB-1:0]  fifo_wadr,
  input  logic [`GEM_RAW_ADRB-1:0]  fifo_radr,
  input  logic [`GEM_SEL_BITS-1:0]  fifo_sel,
  // wishbone
  input  gem_pkg::wb_req_t          wb_req,
  output logic [`GEM_WB_DATB-1:0]   wb_dat_o,
  output logic                      wb_ack,
  // outputs
  output gem_pkg::cluster_vec_t     clusters,   // registered, link or injector
  output logic [`GEM_MXCLST-1:0]    vpf,        // valid per cluster
  output gem_pkg::cluster_t         fifo_rdata, // raw-hits readout
  output logic [`GEM_MXCLST-1:0]    parity_err
);

  logic [`GEM_INJ_ADRB-1:0]  inj_tbin;     // sequencer to injector rams
  logic                      inj_pass;     // source select to the front end
  logic [`GEM_TBIN_BITS-1:0] last_tbin;    // host register to the sequencer
  gem_pkg::cluster_vec_t     inj_clusters; // injector ram outputs

  // ------------------------------
  // control
  // ------------------------------
  gem_inj_sequencer u_seq (
    .clock     (clock),
    .sm_reset  (sm_reset),
    .inj_go    (inj_go),
    .last_tbin (last_tbin),
    .inj_tbin  (inj_tbin),
    .inj_pass  (inj_pass)
  );

  // host access, holds the injector rams
  gem_wb_slave u_wb (
    .clock        (clock),
    .sm_reset     (sm_reset),
    .wb_req       (wb_req),
    .wb_dat_o     (wb_dat_o),
    .wb_ack       (wb_ack),
    .inj_tbin     (inj_tbin),
    .inj_clusters (inj_clusters),
    .last_tbin    (last_tbin)
  );

  // ------------------------------
  // datapath
  // ------------------------------
  gem_cluster_front u_front (
    .clock        (clock),
    .sm_reset     (sm_reset),
    .link_data    (link_data),
    .inj_clusters (inj_clusters),
    .inj_pass     (inj_pass),
    .clusters     (clusters),
    .vpf          (vpf)
  );

  // stores the registered clusters, not the raw link word
  gem_rawhits_store u_raw (
    .clock      (clock),
    .clusters   (clusters),
    .fifo_wen   (fifo_wen),
    .fifo_wadr  (fifo_wadr),
    .fifo_radr  (fifo_radr),
    .fifo_sel   (fifo_sel),
    .fifo_rdata (fifo_rdata),
    .parity_err (parity_err)
  );

endmodule

// ==== verification/gem_tb_assert.sv ====
`include "gem_cfg.svh"

module gem_tb_assert (
  input logic                      clock,
  input logic                      sm_reset,
  input gem_pkg::wb_req_t          wb_req,
  input logic                      wb_ack,
  input logic                      fifo_wen,
  input logic [`GEM_RAW_ADRB-1:0]  fifo_wadr,
  input logic [`GEM_RAW_ADRB-1:0]  fifo_radr,
  input logic [`GEM_MXCLST-1:0]    parity_err,
  input logic [`GEM_LINK_BITS-1:0] link_data, // front end input word
  input logic                      inj_pass,  // 1 = link selected
  input logic [`GEM_MXCLST-1:0]    vpf
);
  timeunit 1ns;
  timeprecision 100ps;

  logic written [`GEM_RAW_DEPTH]; // raw-hits addresses stored so far
  logic written_q = 1'b0;         // current readout comes from a stored word

  initial begin
    for (int i = 0; i < `GEM_RAW_DEPTH; i++) begin
      written[i] = 1'b0;
    end
  end

  always @(posedge clock) begin
    if (fifo_wen) begin
      written[fifo_wadr] <= 1'b1;
    end
    written_q <= written[fifo_radr]; // read first, like the ram
  end

  // ------------------------------
  // wishbone
  // ------------------------------
  a_ack_req: assert property (@(posedge clock) disable iff (sm_reset)
    wb_ack |-> (wb_req.cyc && wb_req.stb)) else $error("ack without cyc and stb");

  a_ack_one: assert property (@(posedge clock) disable iff (sm_reset)
    wb_ack |=> !wb_ack) else $error("ack held two cycles");

  a_parity: assert property (@(posedge clock) disable iff (sm_reset)
    written_q |-> (parity_err == '0)) else $error("raw-hits parity error");

  // ------------------------------
  // valid flags, link word one clock earlier
  // ------------------------------
  genvar iclst;
  generate
    for (iclst = 0; iclst < `GEM_MXCLST; iclst++) begin : g_vpf
      a_vpf: assert property (@(posedge clock) disable iff (sm_reset)
        (!$past(sm_reset) && $past(inj_pass)) |->
          (vpf[iclst] ==
           !(&$past(link_data[iclst*`GEM_CLST_BITS+`GEM_ADR_BITS-2 +: 2])))) // adr 10:9
        else $error("vpf %0d disagrees with its link address", iclst);
    end
  endgenerate

endmodule

bind gem_top gem_tb_assert u_assert (
  .clock      (clock),
  .sm_reset   (sm_reset),
  .wb_req     (wb_req),
  .wb_ack     (wb_ack),
  .fifo_wen   (fifo_wen),
  .fifo_wadr  (fifo_wadr),
  .fifo_radr  (fifo_radr),
  .parity_err (parity_err),
  .link_data  (link_data),
  .inj_pass   (inj_pass),
  .vpf        (vpf)
);

// ==== verification/gem_tb.sv ====
`include "gem_cfg.svh"

module gem_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0]           edge_no; // clock edge where the word shows up
    gem_pkg::cluster_vec_t clst;
  } exp_t;

  typedef struct packed {
    logic valid;  // cluster is not empty
    logic par_hi; // odd parity, bits 13:7
    logic par_lo; // odd parity, bits 6:0
  } ref_t;

  logic                      clock     = 1'b0;
  logic                      sm_reset  = 1'b1;
  logic [`GEM_LINK_BITS-1:0] link_data = '0;
  logic                      inj_go    = 1'b0;
  logic                      fifo_wen  = 1'b0;
  logic [`GEM_RAW_ADRB-1:0]  fifo_wadr = '0;
  logic [`GEM_RAW_ADRB-1:0]  fifo_radr = '0;
  logic [`GEM_SEL_BITS-1:0]  fifo_sel  = '0;
  gem_pkg::wb_req_t          wb_req    = '0;
  logic [`GEM_WB_DATB-1:0]   wb_dat_o;
  logic                      wb_ack;
  gem_pkg::cluster_vec_t     clusters;
  logic [`GEM_MXCLST-1:0]    vpf;
  gem_pkg::cluster_t         fifo_rdata;
  logic [`GEM_MXCLST-1:0]    parity_err;

  logic [31:0]           lfsr       = 32'h9588;
  logic [31:0]           edge_cnt   = '0;  // rising edges so far
  exp_t                  exp_q [$];        // words the compare process waits for
  gem_pkg::cluster_vec_t inj_exp [16];     // injector words by tbin
  logic                  inj_active = 1'b0;
  logic [31:0]           inj_from   = '0;  // first edge with injector data
  logic [31:0]           inj_to     = '0;  // last edge with injector data
  gem_pkg::cluster_vec_t last_word;        // link word driven last
  int                    err_cnt    = 0;

  always #2 clock = ~clock;

  always @(posedge clock) begin
    edge_cnt <= edge_cnt + 1;
  end

  gem_top DUT (.*);

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];          // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic ref_t cluster_ref(input gem_pkg::cluster_t c);
    ref_t r;
    r.valid  = !(c.adr[10] && c.adr[9]); // both set marks an empty cluster
    r.par_lo = ~(^c[6:0]);
    r.par_hi = ~(^c[13:7]);
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      err_cnt++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
      $display("ERRORS FOUND");
      $fatal(1, "first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  endtask

  // random link word, expected at the next edge unless injection covers it
  task automatic drive_link();
    logic [63:0] r;
    exp_t        e;
    take_bits(`GEM_LINK_BITS, r);
    link_data = r[`GEM_LINK_BITS-1:0];
    for (int i = 0; i < `GEM_MXCLST; i++) begin
      last_word[i] = r[i*`GEM_CLST_BITS +: `GEM_CLST_BITS]; // cluster i at 14i
    end
    e.edge_no = edge_cnt + 1;
    e.clst    = last_word;
    if (inj_active && e.edge_no >= inj_from && e.edge_no <= inj_to) begin
      e.clst = inj_exp[e.edge_no - inj_from];
    end
    exp_q.push_back(e);
  endtask

  task automatic drain_queue();
    int n;
    n = 0;
    while (exp_q.size() > 0) begin
      if (n == 20) report_timeout("expected clusters never appeared");
      n++;
      @(negedge clock);
    end
  endtask

  task automatic wb_access(input logic we, input logic [12:0] adr,
                           input logic [15:0] dat, output logic [15:0] rdat);
    int n;
    @(posedge clock);
    #1;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    n = 0;
    @(negedge clock);
    while (!wb_ack) begin
      if (n == 10) report_timeout("no wishbone ack");
      n++;
      @(negedge clock);
    end
    rdat = wb_dat_o;          // valid while ack
    @(posedge clock);
    #1;
    wb_req = '0;              // cycle after ack
  endtask

  task automatic run_injection(input int last);
    @(posedge clock);
    #1;
    inj_go     = 1'b1;
    inj_from   = edge_cnt + 3;        // go seen at next edge, tbin 0 two edges later
    inj_to     = edge_cnt + 3 + last;
    inj_active = 1'b1;
    drive_link();
    @(posedge clock);
    #1;
    inj_go = 1'b0;
    drive_link();
    repeat (last + 6) begin
      @(posedge clock);
      #1;
      drive_link();                   // link comes back after the last tbin
    end
    drain_queue();
    inj_active = 1'b0;
  endtask

  // ------------------------------
  // compare
  // ------------------------------
  always @(negedge clock) begin
    exp_t e;
    ref_t r;
    while (exp_q.size() > 0 && exp_q[0].edge_no <= edge_cnt) begin
      e = exp_q.pop_front();
      for (int i = 0; i < `GEM_MXCLST; i++) begin
        r = cluster_ref(e.clst[i]);
        check_value($sformatf("clusters[%0d]", i), 64'(clusters[i]), 64'(e.clst[i]));
        check_value($sformatf("vpf[%0d]", i), 64'(vpf[i]), 64'(r.valid));
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    logic [63:0]              r;
    logic [15:0]              rd;
    logic [12:0]              adr;
    logic [`GEM_RAW_ADRB-1:0] base;
    ref_t                     pr;
    gem_pkg::cluster_vec_t    raw_model [8];

    repeat (8) @(posedge clock);
    #1;
    sm_reset = 1'b0;

    repeat (40) begin          // link pass-through
      @(posedge clock);
      #1;
      drive_link();
    end
    drain_queue();

    // nothing written yet, every tbin reads as empty
    wb_access(1'b1, `GEM_WB_LAST_TBIN_ADR, 16'd5, rd);
    for (int t = 0; t < 6; t++) begin
      inj_exp[t] = '1;
    end
    run_injection(5);

    for (int n = 0; n < 12; n++) begin
      take_bits(28, r);
      adr = {1'b0, r[27:16]};  // cluster in 11:10, tbin in 9:0
      wb_access(1'b1, adr, r[15:0], rd);
      wb_access(1'b0, adr, 16'h0, rd);
      check_value("wb_dat_o", 64'(rd), 64'(r[15:0]));
    end
    take_bits(16, r);
    wb_access(1'b1, `GEM_WB_LAST_TBIN_ADR, r[15:0], rd);
    wb_access(1'b0, `GEM_WB_LAST_TBIN_ADR, 16'h0, rd);
    check_value("last_tbin readback", 64'(rd), 64'(r[11:0]));
    wb_access(1'b0, 13'h1800, 16'h0, rd);
    check_value("unmapped readback", 64'(rd), 64'h0);

    for (int t = 0; t < 8; t++) begin
      for (int c = 0; c < `GEM_MXCLST; c++) begin
        take_bits(16, r);
        wb_access(1'b1, {1'b0, 2'(c), 10'(t)}, r[15:0], rd);
        inj_exp[t][c] = r[13:0]; // spare bits never reach the front end
      end
    end
    wb_access(1'b1, `GEM_WB_LAST_TBIN_ADR, 16'd7, rd);
    run_injection(7);

    // raw-hits store, each word written the cycle after it is registered
    take_bits(`GEM_RAW_ADRB, r);
    base = r[`GEM_RAW_ADRB-1:0];
    for (int i = 0; i <= 8; i++) begin
      @(posedge clock);
      #1;
      fifo_wen  = (i > 0);
      fifo_wadr = base + 11'(i - 1);
      if (i < 8) begin
        drive_link();
        raw_model[i] = last_word;
      end
    end
    @(posedge clock);
    #1;
    fifo_wen = 1'b0;
    drain_queue();
    for (int i = 0; i < 8; i++) begin
      for (int s = 0; s < `GEM_MXCLST; s++) begin
        @(posedge clock);
        #1;
        fifo_radr = base + 11'(i);
        fifo_sel  = 2'(s);
        @(posedge clock);
        @(negedge clock);          // one cycle read
        pr = cluster_ref(raw_model[i][s]);
        check_value("fifo_rdata", 64'(fifo_rdata), 64'(raw_model[i][s]));
        check_value("parity_err", 64'(parity_err), 64'h0);
        check_value("stored parity", 64'({DUT.u_raw.rd_word[s].par_hi,
                    DUT.u_raw.rd_word[s].par_lo}), 64'({pr.par_hi, pr.par_lo}));
      end
    end

    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/gem_pkg.sv
logic/gem_dpram.sv
logic/gem_inj_sequencer.sv
logic/gem_cluster_front.sv
logic/gem_rawhits_store.sv
logic/gem_wb_slave.sv
logic/gem_top.sv
verification/gem_tb_assert.sv
verification/gem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the gem front end testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module gem_tb \
  -f filelist.f -Mdir obj_dir

out=$(./obj_dir/Vgem_tb 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
